// File: source/prefix_rules.svh
`ifndef PREFIX_RULES_SVH
`define PREFIX_RULES_SVH

// one entry per prefix: region, key value, prefix length
// key bits below the prefix length are kept at zero
localparam prefix_rule_t PREFIX_RULES [NUM_RULES_DEFAULT] = '{

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // first octet 23
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  '{REGION_23,  16'b1110_1100_0011_0000, 5'd12},
  '{REGION_23,  16'b1111_1011_1000_0000, 5'd12},
  '{REGION_23,  16'b1111_1011_1001_0000, 5'd12},

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // first octet 108
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // two adjacent /13 blocks, together one /12
  '{REGION_108, 16'b0011_1011_0101_0000, 5'd13},
  '{REGION_108, 16'b0011_1011_0101_1000, 5'd13},

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // first octet 162
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  '{REGION_162, 16'b1101_1000_1001_0100, 5'd14},
  '{REGION_162, 16'b1101_1110_1011_0000, 5'd13},

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // first octet 173
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  '{REGION_173, 16'b1111_1111_0111_0000, 5'd13},
  '{REGION_173, 16'b1111_1111_0111_1000, 5'd13},

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // first octet 192
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  '{REGION_192, 16'b1001_1110_0001_1100, 5'd14}
};

`endif

// File: source/ip_addr_pkg.sv
`default_nettype none

package ip_addr_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // field widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int ADDR_W  = 32;
  localparam int OCTET_W = 8;
  // middle field, the only part the prefix rules look at
  localparam int KEY_W   = 16;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // address and result
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // msb first, octet is address bits 31:24
  typedef struct packed {
    logic [OCTET_W-1:0]              octet;
    logic [KEY_W-1:0]                key;
    logic [ADDR_W-OCTET_W-KEY_W-1:0] host;
  } ip_addr_t;

  typedef struct packed {
    ip_addr_t addr;
    logic     hit;
  } match_result_t;

endpackage

`default_nettype wire

// File: source/prefix_rule_pkg.sv
`default_nettype none

package prefix_rule_pkg;

  import ip_addr_pkg::*;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // rule regions
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // one code per first octet that has rules
  typedef enum logic [2:0] {
    REGION_NONE = 3'd0,
    REGION_23   = 3'd1,
    REGION_108  = 3'd2,
    REGION_162  = 3'd3,
    REGION_173  = 3'd4,
    REGION_192  = 3'd5
  } region_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // prefix rules
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // len counts leading key bits that must agree, 1 to 16
  typedef struct packed {
    region_e          region;
    logic [KEY_W-1:0] value;
    logic [4:0]       len;
  } prefix_rule_t;

  // entries in the rule list
  localparam int NUM_RULES_DEFAULT = 10;

endpackage

`default_nettype wire

// File: source/prefix_table.sv
`timescale 1ns/1ps
`default_nettype none

module prefix_table
  import ip_addr_pkg::*;
  import prefix_rule_pkg::*;
#(
  // must not exceed the length of the rule list
  parameter int NUM_RULES = NUM_RULES_DEFAULT
) (
  input  logic [KEY_W-1:0] key,
  input  region_e          region,
  output logic             hit
);

  `include "prefix_rules.svh"

  // ones in the top len bits, zeros below
  function automatic logic [KEY_W-1:0] prefix_mask(input logic [4:0] len);
    logic [KEY_W-1:0] mask;
    mask = '1;
    mask = mask << (KEY_W - int'(len));
    return mask;
  endfunction

  logic [NUM_RULES-1:0] rule_hit;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // per-rule compare
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar i = 0; i < NUM_RULES; i++) begin : g_rule
    logic region_ok;
    logic prefix_ok;

    // a rule only counts inside its own region
    assign region_ok = (region != REGION_NONE) && (PREFIX_RULES[i].region == region);

    assign prefix_ok =
      ((key ^ PREFIX_RULES[i].value) & prefix_mask(PREFIX_RULES[i].len)) == '0;

    assign rule_hit[i] = region_ok & prefix_ok;
  end

  assign hit = |rule_hit;

endmodule

`default_nettype wire

// File: source/ip_match_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module ip_match_pipe
  import ip_addr_pkg::*;
  import prefix_rule_pkg::*;
#(
  parameter int NUM_RULES = NUM_RULES_DEFAULT
) (
  input  logic          clk,
  input  logic          arst_n,
  // address side
  input  logic          in_valid,
  output logic          in_ready,
  input  ip_addr_t      in_addr,
  // result side
  output logic          out_valid,
  input  logic          out_ready,
  output match_result_t out_result
);

  // stage 1 holds address and region, stage 2 the finished result
  logic          s1_valid;
  ip_addr_t      s1_addr;
  region_e       s1_region;
  logic          s1_hit;
  logic          s2_valid;
  match_result_t s2_result;

  region_e       in_region;
  logic          in_fire;
  logic          s1_advance;
  logic          s2_free;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // region decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // octets without rules never match
  always_comb begin
    case (in_addr.octet)
      8'd23:   in_region = REGION_23;
      8'd108:  in_region = REGION_108;
      8'd162:  in_region = REGION_162;
      8'd173:  in_region = REGION_173;
      8'd192:  in_region = REGION_192;
      default: in_region = REGION_NONE;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // handshake
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign s2_free    = ~s2_valid | out_ready;
  assign s1_advance = s1_valid & s2_free;
  // a full pipe still takes one address per cycle when the output drains
  assign in_ready   = ~s1_valid | s1_advance;
  assign in_fire    = in_valid & in_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      if (in_fire) begin
        s1_valid <= 1'b1;
      end else if (s1_advance) begin
        s1_valid <= 1'b0;
      end
      if (s1_advance) begin
        s2_valid <= 1'b1;
      end else if (out_ready) begin
        s2_valid <= 1'b0;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // data path
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (in_fire) begin
      s1_addr   <= in_addr;
      s1_region <= in_region;
    end
    if (s1_advance) begin
      s2_result.addr <= s1_addr;
      s2_result.hit  <= s1_hit;
    end
  end

  // compare runs on stage 1 contents
  prefix_table #(
    .NUM_RULES (NUM_RULES)
  ) u_table (
    .key    (s1_addr.key),
    .region (s1_region),
    .hit    (s1_hit)
  );

  assign out_valid  = s2_valid;
  assign out_result = s2_result;

endmodule

`default_nettype wire

// File: source/ip_match.sv
`timescale 1ns/1ps
`default_nettype none

module ip_match
  import ip_addr_pkg::*;
  import prefix_rule_pkg::*;
#(
  // number of prefix rules compared per lookup
  parameter int NUM_RULES = NUM_RULES_DEFAULT
) (
  input  logic          clk,
  input  logic          arst_n,

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // address in
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  input  logic          in_valid,
  output logic          in_ready,
  input  ip_addr_t      in_addr,

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // result out, two stages behind the input
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  output logic          out_valid,
  input  logic          out_ready,
  output match_result_t out_result
);

  ip_match_pipe #(
    .NUM_RULES (NUM_RULES)
  ) u_pipe (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_addr    (in_addr),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_result (out_result)
  );

endmodule

`default_nettype wire

// File: tb/ip_match_vectors.svh
`ifndef IP_MATCH_VECTORS_SVH
`define IP_MATCH_VECTORS_SVH

// columns: name, address, out_ready bit, expected hit
// an out_ready bit of 0 stalls the output for a few cycles
typedef struct packed {
  logic [8*8-1:0] name;
  ip_addr_t       addr;
  logic           rdy;
  logic           hit;
} vector_t;

localparam int NUM_VEC = 20;

localparam vector_t VECTORS [NUM_VEC] = '{
  '{"r23_lo",   32'h17EC_3000, 1'b1, 1'b1},
  '{"r23_hi",   32'h17FB_9FFF, 1'b1, 1'b1},
  '{"r23_out",  32'h17EC_4000, 1'b1, 1'b0},
  '{"r108_lo",  32'h6C3B_5000, 1'b0, 1'b1},
  '{"r108_hi",  32'h6C3B_5FFF, 1'b0, 1'b1},
  '{"r108_out", 32'h6C3B_4FFF, 1'b0, 1'b0},
  '{"r162_lo",  32'hA2D8_9400, 1'b0, 1'b1},
  '{"r162_hi",  32'hA2DE_B7FF, 1'b1, 1'b1},
  '{"r162_out", 32'hA2D8_9800, 1'b1, 1'b0},
  '{"r173_lo",  32'hADFF_7000, 1'b1, 1'b1},
  '{"r173_hi",  32'hADFF_7FFF, 1'b0, 1'b1},
  '{"r173_out", 32'hADFF_8000, 1'b0, 1'b0},
  '{"r192_lo",  32'hC09E_1C00, 1'b1, 1'b1},
  '{"r192_out", 32'hC09E_1BFF, 1'b1, 1'b0},
  '{"drop130",  32'h82D3_0001, 1'b1, 1'b0},
  '{"drop104",  32'h6810_0001, 1'b1, 1'b0},
  '{"drop34",   32'h2240_0001, 1'b1, 1'b0},
  '{"unlisted", 32'h0AEC_3000, 1'b1, 1'b0},
  '{"host_a",   32'hC09E_1FA5, 1'b1, 1'b1},
  '{"host_b",   32'h17EC_4077, 1'b1, 1'b0}
};

// reference rules: first octet, key prefix, prefix length
typedef struct packed {
  logic [OCTET_W-1:0] octet;
  logic [KEY_W-1:0]   value;
  logic [4:0]         len;
} ref_rule_t;

localparam ref_rule_t REF_RULES [NUM_RULES_DEFAULT] = '{
  '{8'd23,  16'hEC30, 5'd12},
  '{8'd23,  16'hFB80, 5'd12},
  '{8'd23,  16'hFB90, 5'd12},
  '{8'd108, 16'h3B50, 5'd13},
  '{8'd108, 16'h3B58, 5'd13},
  '{8'd162, 16'hD894, 5'd14},
  '{8'd162, 16'hDEB0, 5'd13},
  '{8'd173, 16'hFF70, 5'd13},
  '{8'd173, 16'hFF78, 5'd13},
  '{8'd192, 16'h9E1C, 5'd14}
};

`endif

// File: tb/ip_match_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ip_match_tb
  import ip_addr_pkg::*;
  import prefix_rule_pkg::*;
();

  localparam int TIMEOUT_CYC = 50;
  localparam int STALL_CYC   = 4;
  localparam int NUM_RAND    = 200;

  `include "ip_match_vectors.svh"

  logic          clk;
  logic          arst_n;
  logic          in_valid;
  logic          in_ready;
  ip_addr_t      in_addr;
  logic          out_valid;
  logic          out_ready;
  match_result_t out_result;

  // expected results in input order
  match_result_t exp_q[$];
  string         name_q[$];

  logic [31:0] lfsr_state;
  int          errors;
  int          passed;
  int          test_bad;
  int          stall;
  bit          hung;
  bit          saw_full;

  ip_match #(
    .NUM_RULES (NUM_RULES_DEFAULT)
  ) UUT (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_addr    (in_addr),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_result (out_result)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model and lfsr
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic region_e model_region(input logic [OCTET_W-1:0] octet);
    case (octet)
      8'd23:   return REGION_23;
      8'd108:  return REGION_108;
      8'd162:  return REGION_162;
      8'd173:  return REGION_173;
      8'd192:  return REGION_192;
      default: return REGION_NONE;
    endcase
  endfunction

  // top len bits of the key must agree with the rule
  function automatic logic model_hit(input ip_addr_t a);
    logic [KEY_W-1:0] diff;
    for (int r = 0; r < NUM_RULES_DEFAULT; r++) begin
      diff = a.key ^ REF_RULES[r].value;
      if (REF_RULES[r].octet == a.octet && (diff >> (KEY_W - REF_RULES[r].len)) == '0) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  function automatic logic lfsr_bit();
    logic lsb;
    lsb = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (lsb) begin
      lfsr_state = lfsr_state ^ 32'hB4BC_D35C;
    end
    return lsb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // compare tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic check_result(input string name, input match_result_t exp,
                              input match_result_t act);
    if (act !== exp) begin
      $display("mismatch %s: expected addr %h hit %b, actual addr %h hit %b",
               name, exp.addr, exp.hit, act.addr, act.hit);
      test_bad++;
    end
  endtask

  task automatic check_region(input string name, input region_e exp, input region_e act);
    if (act !== exp) begin
      $display("mismatch %s: expected region %s, actual region %s",
               name, exp.name(), act.name());
      test_bad++;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // driver and collector
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic step_ready();
    if (stall > 0) begin
      out_ready = 1'b0;
      stall--;
    end else begin
      out_ready = 1'b1;
    end
  endtask

  task automatic send(input string name, input ip_addr_t addr, input logic rdy,
                      input logic hit);
    int waited;
    waited = 0;
    exp_q.push_back('{addr: addr, hit: hit});
    name_q.push_back(name);
    @(negedge clk);
    in_valid = 1'b1;
    in_addr  = addr;
    if (!rdy) begin
      stall = STALL_CYC;
    end
    step_ready();
    @(posedge clk);
    while (!in_ready && !hung) begin
      saw_full = 1'b1;
      // in_ready may only drop while stage 2 is held
      if (!(out_valid && !out_ready)) begin
        $display("in_ready low at %s although the output was not stalled", name);
        errors++;
      end
      waited++;
      if (waited >= TIMEOUT_CYC) begin
        $display("timeout: in_ready stayed low while sending %s", name);
        errors++;
        hung = 1'b1;
      end else begin
        @(negedge clk);
        step_ready();
        @(posedge clk);
      end
    end
  endtask

  task automatic drive_all();
    ip_addr_t         addr;
    int               pick;
    logic [KEY_W-1:0] keep;
    for (int i = 0; i < NUM_VEC && !hung; i++) begin
      send($sformatf("%0s", VECTORS[i].name), VECTORS[i].addr, VECTORS[i].rdy,
           VECTORS[i].hit);
    end
    for (int i = 0; i < NUM_RAND && !hung; i++) begin
      addr = rand_bits(32);
      if (i % 2 == 0) begin
        pick = rand_bits(4) % NUM_RULES_DEFAULT;
        addr.octet = REF_RULES[pick].octet;
        // often keep the rule prefix so that hits show up
        if (lfsr_bit()) begin
          keep = {KEY_W{1'b1}} << (KEY_W - int'(REF_RULES[pick].len));
          addr.key = (REF_RULES[pick].value & keep) | (addr.key & ~keep);
        end
      end
      send($sformatf("rand%0d", i), addr, rand_bits(3) != 0, model_hit(addr));
    end
    @(negedge clk);
    in_valid  = 1'b0;
    stall     = 0;
    out_ready = 1'b1;
  endtask

  task automatic collect_all();
    match_result_t exp;
    string         name;
    int            waited;
    for (int n = 0; n < NUM_VEC + NUM_RAND && !hung; n++) begin
      waited = 0;
      @(posedge clk);
      while (!(out_valid && out_ready) && !hung) begin
        waited++;
        if (waited >= TIMEOUT_CYC) begin
          $display("timeout: no result handshake for result %0d", n);
          errors++;
          hung = 1'b1;
        end else begin
          @(posedge clk);
        end
      end
      if (!hung) begin
        exp  = exp_q.pop_front();
        name = name_q.pop_front();
        test_bad = 0;
        check_result(name, exp, out_result);
        check_region(name, model_region(exp.addr.octet), model_region(out_result.addr.octet));
        if (test_bad == 0) begin
          passed++;
          $display("test %s ok", name);
        end else begin
          errors++;
          $display("test %s failed", name);
        end
      end
    end
    // duplicates would show up as extra results
    for (int c = 0; c < 4; c++) begin
      @(posedge clk);
      if (out_valid) begin
        $display("extra result %h after the last expected one", out_result.addr);
        errors++;
      end
    end
  endtask

  initial begin
    arst_n     = 1'b0;
    in_valid   = 1'b0;
    in_addr    = '0;
    out_ready  = 1'b1;
    lfsr_state = 32'h8b72;
    errors     = 0;
    passed     = 0;
    stall      = 0;
    hung       = 1'b0;
    saw_full   = 1'b0;
    repeat (3) @(negedge clk);
    arst_n = 1'b1;
    if (in_ready !== 1'b1 || out_valid !== 1'b0) begin
      $display("after reset in_ready is not high or out_valid is not low");
      errors++;
    end
    fork
      drive_all();
      collect_all();
    join
    if (!saw_full) begin
      $display("in_ready never fell while the output was stalled");
      errors++;
    end
    $display("%0d tests passed, %0d failures", passed, errors);
    if (errors == 0 && !hung) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+source
+incdir+tb
source/ip_addr_pkg.sv
source/prefix_rule_pkg.sv
source/prefix_table.sv
source/ip_match_pipe.sv
source/ip_match.sv
tb/ip_match_tb.sv

// File: Bender.yml
package:
  name: ip_match

sources:
  - include_dirs:
      - source
    files:
      - source/ip_addr_pkg.sv
      - source/prefix_rule_pkg.sv
      - source/prefix_table.sv
      - source/ip_match_pipe.sv
      - source/ip_match.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/ip_match_tb.sv
